// File: verilog.f
+incdir+bench
verilog/pcie_tx_pkg.sv
verilog/completion_queue.sv
verilog/read_request_queue.sv
verilog/write_burst_buffer.sv
verilog/pcie_tx.sv
verilog/pcie_tx_top.sv
bench/tb_pcie_tx_top.sv

// File: run_sim.sh
#!/bin/bash
# build and run the pcie tx testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f \
   --top-module tb_pcie_tx_top \
   -o sim_tb

./obj_dir/sim_tb | tee sim.log || true

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
   echo "no pass line in sim.log"
   exit 1
fi
exit 0

// File: bench/tb_tlp_model.svh
`ifndef TB_TLP_MODEL_SVH
`define TB_TLP_MODEL_SVH

axis_beat_t  exp_q[$];       // beats still due for the current packet
cpl_entry_t  cpl_q[$];
logic [63:0] rd_addr_q[$];
logic [63:0] wr_addr_q[$];
logic [63:0] wr_word_q[$];
logic        tag_busy [max_outstanding];
int          tag_next;

function automatic logic [31:0] byte_reverse(input logic [31:0] d);
   return {<<8{d}};
endfunction

function automatic int expected_tag();
   int idx;
   for (int i = 0; i < max_outstanding; i++)
   begin
      idx = (tag_next + i) % max_outstanding;
      if (!tag_busy[idx])
         return idx;
   end
   return -1;
endfunction

task automatic add_beat(input logic [63:0] d, input logic one_dw, input logic last);
   axis_beat_t b;
   b.tdata = d;
   b.one_dw = one_dw;
   b.last = last;
   exp_q.push_back(b);
endtask

task automatic expect_cpl(input cpl_entry_t c, input logic [15:0] id);
   tlp_hdr01_u h;
   h = '0;
   h.cpl.fmt_type = 8'h4a;   // CplD
   h.cpl.length = 24'd2;
   h.cpl.completer_id = id;
   h.cpl.byte_count = 16'd8;
   add_beat(h, 1'b0, 1'b0);
   add_beat({byte_reverse(c.data[31:0]), c.rid_tag, 1'b0, c.lower_addr, 3'd0}, 1'b0, 1'b0);
   add_beat({32'h0, byte_reverse(c.data[63:32])}, 1'b1, 1'b1);
endtask

task automatic expect_req_hdr(input logic [7:0] fmt, input logic [23:0] len,
                              input logic [7:0] tag, input logic [15:0] id);
   tlp_hdr01_u h;
   h = '0;
   h.req.fmt_type = fmt;
   h.req.length = len;
   h.req.requester_id = id;
   h.req.tag = tag;
   h.req.byte_en = 8'hff;
   add_beat(h, 1'b0, 1'b0);
endtask

task automatic expect_rd(input logic [63:0] a, input logic [7:0] tag, input logic [15:0] id);
   logic short_addr;
   short_addr = a[63:32] == 32'h0;
   expect_req_hdr(short_addr ? 8'h00 : 8'h20, 24'd128, tag, id);
   if (short_addr)
      add_beat({32'h0, a[31:0]}, 1'b1, 1'b1);
   else
      add_beat({a[31:0], a[63:32]}, 1'b0, 1'b1);
endtask

task automatic expect_wr(input logic [63:0] a, input logic [15:0] id);
   logic [31:0] lo [16];
   logic [31:0] hi [16];
   logic        short_addr;
   short_addr = a[63:32] == 32'h0;
   for (int k = 0; k < 16; k++)
   begin
      lo[k] = byte_reverse(wr_word_q[0][31:0]);
      hi[k] = byte_reverse(wr_word_q[0][63:32]);
      void'(wr_word_q.pop_front());
   end
   expect_req_hdr(short_addr ? 8'h40 : 8'h60, 24'd32, 8'h00, id);
   if (short_addr)
   begin
      add_beat({lo[0], a[31:0]}, 1'b0, 1'b0);   // dword shifted by the 3dw header
      for (int k = 1; k < 16; k++)
         add_beat({lo[k], hi[k-1]}, 1'b0, 1'b0);
      add_beat({32'h0, hi[15]}, 1'b1, 1'b1);
   end
   else
   begin
      add_beat({a[31:0], a[63:32]}, 1'b0, 1'b0);
      for (int k = 0; k < 16; k++)
         add_beat({hi[k], lo[k]}, 1'b0, k == 15);
   end
endtask

`endif

// File: bench/tb_pcie_tx_top.sv
`timescale 1ns/10ps

module tb_pcie_tx_top import pcie_tx_pkg::*;;

   localparam int max_outstanding = 8;
   localparam int wait_limit = 4000;

   logic        clock;
   logic        reset;
   logic [15:0] pcie_id;
   logic        cpl_in_valid;
   cpl_entry_t  cpl_in;
   logic        cpl_in_full;
   logic        rd_addr_valid;
   logic [63:0] rd_addr;
   logic        rd_full;
   logic        tag_release;
   logic [7:0]  release_tag;
   logic        wr_start;
   logic [63:0] wr_addr;
   logic        wr_word_valid;
   logic [63:0] wr_word;
   logic        wr_busy;
   logic        tx_ready;
   axis_beat_t  tx_beat;
   logic        tx_valid;

   logic [31:0] lfsr = 32'h9eeef578;
   logic        hold_ready;
   int          sent [3];   // cpl, rd, wr
   int          done [3];
   int          kind_log[$];
   int          cur_kind;
   int          cur_tag;    // tag of the read in flight
   logic        held_valid;
   axis_beat_t  held_beat;

   `include "tb_tlp_model.svh"

   pcie_tx_top #(.max_outstanding(max_outstanding)) pcie_tx_top_i (.*);

   initial
   begin
      clock = 1'b0;
      forever #4 clock = ~clock;
   end

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r = {r[62:0], fb};
      end
      return r;
   endfunction

   task automatic die(input string msg);
      $display("%s at %0t", msg, $time);
      $display("Simulation failed");
      $fatal(1, "stopped on first error");
   endtask

   task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t got);
      if (got !== exp)
      begin
         $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
         $display("Simulation failed");
         $fatal(1, "stopped on first error");
      end
   endtask

   task automatic check_tag(input string name, input logic [7:0] exp, input logic [7:0] got);
      if (got !== exp)
      begin
         $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
         $display("Simulation failed");
         $fatal(1, "stopped on first error");
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic got);
      if (got !== exp)
      begin
         $display("FAIL %0t %s expected %b got %b", $time, name, exp, got);
         $display("Simulation failed");
         $fatal(1, "stopped on first error");
      end
   endtask

   // roughly 30% of cycles with no ready
   always @(negedge clock)
      tx_ready = hold_ready ? 1'b0 : rand_bits(4) >= 64'd5;

   task automatic start_packet(input axis_beat_t b);
      tlp_hdr01_u h;
      int         t;
      h = b.tdata;
      case (h.req.fmt_type)
         8'h4a:
         begin
            if (cpl_q.size() == 0)
               die("completion sent that was never pushed");
            cur_kind = 0;
            expect_cpl(cpl_q.pop_front(), pcie_id);
         end
         8'h00, 8'h20:
         begin
            t = expected_tag();
            if (rd_addr_q.size() == 0 || t < 0)
               die("read request sent without a queued address or free tag");
            cur_kind = 1;
            cur_tag = t;
            check_tag("tx_beat.tag", 8'(t), h.req.tag);
            expect_rd(rd_addr_q.pop_front(), 8'(t), pcie_id);
         end
         8'h40, 8'h60:
         begin
            if (wr_addr_q.size() == 0)
               die("write sent that was never started");
            cur_kind = 2;
            expect_wr(wr_addr_q.pop_front(), pcie_id);
         end
         default: die("first beat of a packet has an unknown format");
      endcase
   endtask

   always @(posedge clock)
   begin
      if (reset)
         held_valid = 1'b0;
      else
      begin
         if (held_valid)
         begin
            if (!tx_valid)
               die("tx_valid dropped while tx_ready was low");
            check_beat("tx_beat (held)", held_beat, tx_beat);
         end
         held_valid = tx_valid && !tx_ready;
         held_beat = tx_beat;
         if (tx_valid && tx_ready)
         begin
            if (exp_q.size() == 0)
               start_packet(tx_beat);
            check_beat("tx_beat", exp_q.pop_front(), tx_beat);
            if (tx_beat.last)
            begin
               if (cur_kind == 1)
               begin
                  tag_busy[cur_tag] = 1'b1;
                  tag_next = (cur_tag + 1) % max_outstanding;
               end
               kind_log.push_back(cur_kind);
               done[cur_kind]++;
            end
         end
      end
   end

   // waits until every packet handed in has left the port
   task automatic wait_all_done(input string what);
      int n;
      n = 0;
      while (done[0] != sent[0] || done[1] != sent[1] || done[2] != sent[2])
      begin
         @(negedge clock);
         n++;
         if (n > wait_limit)
            die({"timeout waiting for ", what});
      end
   endtask

   task automatic push_cpl();
      int n;
      n = 0;
      while (cpl_in_full)
      begin
         @(negedge clock);
         if (++n > wait_limit)
            die("timeout waiting for completion queue space");
      end
      cpl_in_valid = 1'b1;
      cpl_in.rid_tag = 24'(rand_bits(24));
      cpl_in.lower_addr = 4'(rand_bits(4));
      cpl_in.data = rand_bits(64);
      cpl_q.push_back(cpl_in);
      sent[0]++;
      @(negedge clock);
      cpl_in_valid = 1'b0;
   endtask

   task automatic push_rd();
      int n;
      n = 0;
      while (rd_full)
      begin
         @(negedge clock);
         if (++n > wait_limit)
            die("timeout waiting for read queue space");
      end
      rd_addr_valid = 1'b1;
      rd_addr[31:0] = 32'(rand_bits(32));
      rd_addr[63:32] = rand_bits(1) ? 32'(rand_bits(32)) | 32'h1 : 32'h0;
      rd_addr_q.push_back(rd_addr);
      sent[1]++;
      @(negedge clock);
      rd_addr_valid = 1'b0;
   endtask

   task automatic push_write();
      int n;
      n = 0;
      while (wr_busy)
      begin
         @(negedge clock);
         if (++n > wait_limit)
            die("timeout waiting for the write buffer to drain");
      end
      wr_start = 1'b1;
      wr_addr[31:0] = 32'(rand_bits(32));
      wr_addr[63:32] = rand_bits(1) ? 32'(rand_bits(32)) | 32'h1 : 32'h0;
      wr_addr_q.push_back(wr_addr);
      @(negedge clock);
      wr_start = 1'b0;
      check_flag("wr_busy", 1'b1, wr_busy);
      for (int k = 0; k < words_per_burst; k++)
      begin
         if (rand_bits(2) == 0)
            @(negedge clock);   // gap between words
         wr_word_valid = 1'b1;
         wr_word = rand_bits(64);
         wr_word_q.push_back(wr_word);
         @(negedge clock);
         wr_word_valid = 1'b0;
      end
      sent[2]++;
   endtask

   task automatic release_one(input int t);
      tag_release = 1'b1;
      release_tag = 8'(t);
      tag_busy[t] = 1'b0;
      @(negedge clock);
      tag_release = 1'b0;
   endtask

   task automatic release_all();
      for (int t = 0; t < max_outstanding; t++)
         if (tag_busy[t])
            release_one(t);
   endtask

   initial
   begin
      int n;
      reset = 1'b1;
      pcie_id = 16'h01a8;
      cpl_in_valid = 1'b0;
      cpl_in = '0;
      rd_addr_valid = 1'b0;
      rd_addr = '0;
      tag_release = 1'b0;
      release_tag = '0;
      wr_start = 1'b0;
      wr_addr = '0;
      wr_word_valid = 1'b0;
      wr_word = '0;
      tx_ready = 1'b0;
      hold_ready = 1'b0;
      tag_next = 0;
      cur_tag = 0;
      for (int t = 0; t < max_outstanding; t++)
         tag_busy[t] = 1'b0;
      repeat (10) @(negedge clock);
      reset = 1'b0;
      check_flag("tx_valid", 1'b0, tx_valid);
      check_flag("wr_busy", 1'b0, wr_busy);
      check_flag("cpl_in_full", 1'b0, cpl_in_full);
      check_flag("rd_full", 1'b0, rd_full);

      repeat (6) push_cpl();
      wait_all_done("completions");

      // use up every tag, then one more read must wait
      repeat (max_outstanding) push_rd();
      wait_all_done("reads");
      push_rd();
      repeat (200) @(negedge clock);
      if (done[1] != max_outstanding)
         die("read request sent while every tag was outstanding");
      release_one(int'(rand_bits(3)) % max_outstanding);
      wait_all_done("read after tag release");
      release_all();

      repeat (4) push_write();
      wait_all_done("write bursts");
      check_flag("wr_busy", 1'b0, wr_busy);

      // stall on a completion so that all sources wait at idle
      hold_ready = 1'b1;
      push_cpl();
      n = 0;
      while (!tx_valid)
      begin
         @(negedge clock);
         if (++n > wait_limit)
            die("timeout waiting for the first completion beat");
      end
      push_write();
      push_rd();
      push_cpl();
      repeat (3) @(negedge clock);
      kind_log.delete();
      hold_ready = 1'b0;
      wait_all_done("arbitration packets");
      if (kind_log.size() != 4 || kind_log[0] != 0 || kind_log[1] != 0 ||
          kind_log[2] != 1 || kind_log[3] != 2)
         die("packets did not leave in completion, read, write order");
      release_all();

      for (int round = 0; round < 3; round++)
      begin
         repeat (int'(rand_bits(2)) % 3) push_cpl();
         repeat (int'(rand_bits(2)) % 3) push_rd();
         if (rand_bits(1))
            push_write();
         push_cpl();
         wait_all_done("mixed traffic");
         release_all();
      end

      repeat (5) @(negedge clock);
      if (exp_q.size() != 0 || cpl_q.size() != 0 || rd_addr_q.size() != 0 ||
          wr_addr_q.size() != 0)
      begin
         $display("expected packets were never sent");
         $display("Simulation failed");
         $fatal(1, "stopped at end of test");
      end
      else
      begin
         $display("Simulation completed successfully");
         $finish;
      end
   end

endmodule

// File: verilog/pcie_tx_top.sv
`timescale 1ns/10ps

module pcie_tx_top import pcie_tx_pkg::*;
#(
   parameter int completion_depth = 4,
   parameter int read_queue_depth = 4,
   parameter int max_outstanding  = 8
)
(
   input  logic        clock,
   input  logic        reset,
   input  logic [15:0] pcie_id,
   // completions
   input  logic        cpl_in_valid,
   input  cpl_entry_t  cpl_in,
   output logic        cpl_in_full,
   // read requests
   input  logic        rd_addr_valid,
   input  logic [63:0] rd_addr,
   output logic        rd_full,
   input  logic        tag_release,
   input  logic [7:0]  release_tag,
   // write bursts
   input  logic        wr_start,
   input  logic [63:0] wr_addr,
   input  logic        wr_word_valid,
   input  logic [63:0] wr_word,
   output logic        wr_busy,
   // stream to the hard core
   input  logic        tx_ready,
   output axis_beat_t  tx_beat,
   output logic        tx_valid
);

   logic        cpl_valid;
   cpl_entry_t  cpl_head;
   logic        cpl_pop;
   logic        rd_valid;
   rd_req_t     rd_head;
   logic        rd_pop;
   logic        wr_valid;
   wr_hdr_t     wr_head;
   logic [63:0] wr_data;
   logic        wr_word_ready;

   completion_queue #(.completion_depth(completion_depth)) completion_queue_i (.*);

   read_request_queue #(
      .read_queue_depth(read_queue_depth),
      .max_outstanding (max_outstanding)
   ) read_request_queue_i (.*);

   write_burst_buffer write_burst_buffer_i (.*);

   pcie_tx pcie_tx_i (.*);

endmodule

// File: verilog/pcie_tx.sv
`timescale 1ns/10ps

module pcie_tx import pcie_tx_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic [15:0] pcie_id,
   input  logic        cpl_valid,
   input  cpl_entry_t  cpl_head,
   output logic        cpl_pop,
   input  logic        rd_valid,
   input  rd_req_t     rd_head,
   output logic        rd_pop,
   input  logic        wr_valid,
   input  wr_hdr_t     wr_head,
   input  logic [63:0] wr_data,
   output logic        wr_word_ready,
   input  logic        tx_ready,
   output axis_beat_t  tx_beat,
   output logic        tx_valid
);

   localparam logic [1:0] k_idle = 2'd0;
   localparam logic [1:0] k_cpl  = 2'd1;
   localparam logic [1:0] k_rd   = 2'd2;
   localparam logic [1:0] k_wr   = 2'd3;
   localparam logic [4:0] wr_last = 5'(words_per_burst + 1);

   logic [1:0]  kind;
   logic [4:0]  beat_idx;   // next beat to load
   logic        tail;       // last beat already loaded
   logic        is_3dw;
   logic [31:0] prev_hi;
   logic [63:0] word_sw;
   logic        takes_word;
   logic        load;
   logic        accept;
   tlp_hdr01_u  hdr;
   axis_beat_t  next_beat;

   assign accept  = tx_valid && tx_ready;
   assign load    = kind != k_idle && !tail && (!tx_valid || tx_ready);
   assign word_sw = {swap_dw(wr_data[63:32]), swap_dw(wr_data[31:0])};

   // 3dw carries word 0 in the address beat
   assign takes_word = is_3dw ? (beat_idx >= 5'd1 && beat_idx < wr_last)
                              : (beat_idx >= 5'd2 && beat_idx <= wr_last);

   assign wr_word_ready = load && kind == k_wr && takes_word;
   assign cpl_pop       = accept && tx_beat.last && kind == k_cpl;
   assign rd_pop        = accept && tx_beat.last && kind == k_rd;

   always_comb
   begin
      hdr = '0;
      next_beat = '0;
      if (kind == k_cpl)
      begin
         hdr.cpl.fmt_type     = fmt_cpld;
         hdr.cpl.length       = 24'd2;
         hdr.cpl.completer_id = pcie_id;
         hdr.cpl.byte_count   = 16'd8;
      end
      else if (kind == k_rd)
      begin
         hdr.req.fmt_type     = is_3dw ? fmt_mrd32 : fmt_mrd64;
         hdr.req.length       = rd_len_dw;
         hdr.req.requester_id = pcie_id;
         hdr.req.tag          = rd_head.tag;
         hdr.req.byte_en      = 8'hff;
      end
      else
      begin
         hdr.req.fmt_type     = is_3dw ? fmt_mwr32 : fmt_mwr64;
         hdr.req.length       = wr_len_dw;
         hdr.req.requester_id = pcie_id;
         hdr.req.byte_en      = 8'hff;
      end

      if (beat_idx == 5'd0)
         next_beat.tdata = hdr;
      else if (kind == k_cpl)
      begin
         if (beat_idx == 5'd1)
            next_beat.tdata = {swap_dw(cpl_head.data[31:0]), cpl_head.rid_tag, 1'b0,
                               cpl_head.lower_addr, 3'd0};
         else
         begin
            next_beat.tdata  = {32'h0, swap_dw(cpl_head.data[63:32])};
            next_beat.one_dw = 1'b1;
            next_beat.last   = 1'b1;
         end
      end
      else if (kind == k_rd)
      begin
         next_beat.tdata  = is_3dw ? {32'h0, rd_head.addr[31:0]}
                                   : {rd_head.addr[31:0], rd_head.addr[63:32]};
         next_beat.one_dw = is_3dw;
         next_beat.last   = 1'b1;
      end
      else if (beat_idx == 5'd1)
         next_beat.tdata = is_3dw ? {word_sw[31:0], wr_head.addr[31:0]}
                                  : {wr_head.addr[31:0], wr_head.addr[63:32]};
      else if (is_3dw)
      begin
         // low half of this word paired with high half of the last
         next_beat.tdata  = beat_idx == wr_last ? {32'h0, prev_hi} : {word_sw[31:0], prev_hi};
         next_beat.one_dw = beat_idx == wr_last;
         next_beat.last   = beat_idx == wr_last;
      end
      else
      begin
         next_beat.tdata = word_sw;
         next_beat.last  = beat_idx == wr_last;
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         kind     <= k_idle;
         beat_idx <= 5'd0;
         tail     <= 1'b0;
         tx_valid <= 1'b0;
      end
      else if (kind == k_idle)
      begin
         beat_idx <= 5'd0;
         tail     <= 1'b0;
         if (cpl_valid)
            kind <= k_cpl;
         else if (rd_valid)
            kind <= k_rd;
         else if (wr_valid)
            kind <= k_wr;
      end
      else
      begin
         if (load)
         begin
            beat_idx <= beat_idx + 5'd1;
            tail     <= next_beat.last;
            tx_valid <= 1'b1;
         end
         else if (accept)
            tx_valid <= 1'b0;
         if (accept && tx_beat.last)
            kind <= k_idle;
      end
   end

   always_ff @(posedge clock)
   begin
      if (kind == k_idle)   // only read and write look at the format
         is_3dw <= rd_valid ? rd_head.addr[63:32] == 32'h0 : wr_head.addr[63:32] == 32'h0;
      if (load)
         tx_beat <= next_beat;
      if (wr_word_ready)
         prev_hi <= swap_dw(wr_data[63:32]);
   end

   a_beat_stable: assert property (@(posedge clock) disable iff (reset)
      tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat));

   // no pop or word strobe while the port stalls
   a_no_strobe_stalled: assert property (@(posedge clock) disable iff (reset)
      !tx_ready |-> !(cpl_pop || rd_pop || wr_word_ready));

endmodule

// File: verilog/write_burst_buffer.sv
`timescale 1ns/10ps

module write_burst_buffer import pcie_tx_pkg::*;
(
   input  logic        clock,
   input  logic        reset,
   input  logic        wr_start,
   input  logic [63:0] wr_addr,
   input  logic        wr_word_valid,
   input  logic [63:0] wr_word,
   input  logic        wr_word_ready,
   output logic        wr_busy,
   output logic        wr_valid,
   output wr_hdr_t     wr_head,
   output logic [63:0] wr_data
);

   localparam int idx_w = $clog2(words_per_burst);
   localparam logic [idx_w-1:0] last_idx = idx_w'(words_per_burst - 1);

   logic [63:0]      mem [words_per_burst];
   logic [idx_w:0]   fill_cnt;
   logic [idx_w-1:0] drain_cnt;
   logic             fill_done;
   logic             take_word;
   logic             start;

   assign start     = wr_start && !wr_busy;   // start while busy is dropped
   assign fill_done = fill_cnt == (idx_w + 1)'(words_per_burst);
   assign take_word = wr_busy && wr_word_valid && !fill_done;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_busy   <= 1'b0;
         wr_valid  <= 1'b0;
         fill_cnt  <= '0;
         drain_cnt <= '0;
      end
      else
      begin
         if (start)
         begin
            wr_busy   <= 1'b1;
            fill_cnt  <= '0;
            drain_cnt <= '0;
         end
         if (take_word)
         begin
            fill_cnt <= fill_cnt + 1'b1;
            if (fill_cnt[idx_w-1:0] == last_idx)
               wr_valid <= 1'b1;
         end
         if (wr_word_ready)
         begin
            drain_cnt <= drain_cnt + 1'b1;
            if (drain_cnt == last_idx)
            begin
               wr_valid <= 1'b0;
               wr_busy  <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (start)
         wr_head.addr <= wr_addr;
      if (take_word)
         mem[fill_cnt[idx_w-1:0]] <= wr_word;
      if (take_word && fill_cnt[idx_w-1:0] == last_idx)
         wr_data <= mem[0];   // first word ready with wr_valid
      else if (wr_word_ready)
         wr_data <= mem[drain_cnt + 1'b1];
   end

   a_ready_needs_valid: assert property (@(posedge clock) disable iff (reset)
      wr_word_ready |-> wr_valid);

endmodule

// File: verilog/read_request_queue.sv
`timescale 1ns/10ps

module read_request_queue import pcie_tx_pkg::*;
#(
   parameter int read_queue_depth = 4,
   parameter int max_outstanding  = 8
)
(
   input  logic        clock,
   input  logic        reset,
   input  logic        rd_addr_valid,
   input  logic [63:0] rd_addr,
   input  logic        rd_pop,
   input  logic        tag_release,
   input  logic [7:0]  release_tag,
   output logic        rd_full,
   output logic        rd_valid,
   output rd_req_t     rd_head
);

   localparam int ptr_w = $clog2(read_queue_depth);
   localparam int cnt_w = $clog2(read_queue_depth + 1);
   localparam int tag_w = $clog2(max_outstanding);

   logic [63:0]                mem [read_queue_depth];
   logic [ptr_w-1:0]           wr_ptr;
   logic [ptr_w-1:0]           rd_ptr;
   logic [cnt_w-1:0]           count;
   logic                       push;
   logic [max_outstanding-1:0] outstanding;
   logic [tag_w-1:0]           tag_ptr;
   logic [tag_w-1:0]           free_tag;
   logic                       tag_found;

   assign rd_full      = count == cnt_w'(read_queue_depth);
   assign push         = rd_addr_valid && !rd_full;
   assign rd_valid     = count != '0 && tag_found;
   assign rd_head.addr = mem[rd_ptr];
   assign rd_head.tag  = 8'(free_tag);

   // first free tag at or after the rolling pointer
   always_comb
   begin
      int idx;
      free_tag  = '0;
      tag_found = 1'b0;
      for (int i = max_outstanding - 1; i >= 0; i--)
      begin
         idx = (int'(tag_ptr) + i) % max_outstanding;
         if (!outstanding[idx])
         begin
            free_tag  = tag_w'(idx);
            tag_found = 1'b1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         outstanding <= '0;
         tag_ptr     <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr == ptr_w'(read_queue_depth - 1) ? '0 : wr_ptr + 1'b1;
         if (rd_pop)
            rd_ptr <= rd_ptr == ptr_w'(read_queue_depth - 1) ? '0 : rd_ptr + 1'b1;
         count <= count + cnt_w'(push) - cnt_w'(rd_pop);
         if (tag_release)
            outstanding[release_tag[tag_w-1:0]] <= 1'b0;
         if (rd_pop)
         begin
            outstanding[free_tag] <= 1'b1;
            tag_ptr <= free_tag == tag_w'(max_outstanding - 1) ? '0 : free_tag + 1'b1;
         end
      end
   end

   always_ff @(posedge clock)
   begin
      if (push)
         mem[wr_ptr] <= rd_addr;
   end

   a_release_known: assert property (@(posedge clock) disable iff (reset)
      tag_release |-> release_tag < max_outstanding && outstanding[release_tag[tag_w-1:0]]);

endmodule

// File: verilog/completion_queue.sv
`timescale 1ns/10ps

module completion_queue import pcie_tx_pkg::*;
#(
   parameter int completion_depth = 4
)
(
   input  logic       clock,
   input  logic       reset,
   input  logic       cpl_in_valid,
   input  cpl_entry_t cpl_in,
   input  logic       cpl_pop,
   output logic       cpl_in_full,
   output logic       cpl_valid,
   output cpl_entry_t cpl_head
);

   localparam int ptr_w = $clog2(completion_depth);
   localparam int cnt_w = $clog2(completion_depth + 1);

   cpl_entry_t       mem [completion_depth];
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;

   assign cpl_in_full = count == cnt_w'(completion_depth);
   assign push        = cpl_in_valid && !cpl_in_full;
   assign cpl_valid   = count != '0;
   assign cpl_head    = mem[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr == ptr_w'(completion_depth - 1) ? '0 : wr_ptr + 1'b1;
         if (cpl_pop)
            rd_ptr <= rd_ptr == ptr_w'(completion_depth - 1) ? '0 : rd_ptr + 1'b1;
         count <= count + cnt_w'(push) - cnt_w'(cpl_pop);
      end
   end

   always_ff @(posedge clock)
   begin
      if (push)
         mem[wr_ptr] <= cpl_in;
   end

   a_no_empty_pop: assert property (@(posedge clock) disable iff (reset)
      cpl_pop |-> cpl_valid);

endmodule

// File: verilog/pcie_tx_pkg.sv
package pcie_tx_pkg;

   localparam int words_per_burst = 16;   // 128 byte write

   // fmt/type byte of header dword 0
   localparam logic [7:0] fmt_mrd32 = 8'h00;
   localparam logic [7:0] fmt_mrd64 = 8'h20;
   localparam logic [7:0] fmt_mwr32 = 8'h40;
   localparam logic [7:0] fmt_mwr64 = 8'h60;
   localparam logic [7:0] fmt_cpld  = 8'h4a;

   localparam logic [23:0] rd_len_dw = 24'd128;   // 512 bytes
   localparam logic [23:0] wr_len_dw = 24'd32;

   typedef struct packed {
      logic [63:0] tdata;
      logic        one_dw;
      logic        last;
   } axis_beat_t;

   typedef struct packed {
      logic [23:0] rid_tag;
      logic [3:0]  lower_addr;
      logic [63:0] data;
   } cpl_entry_t;

   typedef struct packed {
      logic [63:0] addr;
      logic [7:0]  tag;
   } rd_req_t;

   typedef struct packed {
      logic [63:0] addr;
   } wr_hdr_t;

   // dword 1 in the upper half, dword 0 in the lower
   typedef struct packed {
      logic [15:0] requester_id;
      logic [7:0]  tag;
      logic [7:0]  byte_en;
      logic [7:0]  fmt_type;
      logic [23:0] length;
   } tlp_req_hdr_t;

   typedef struct packed {
      logic [15:0] completer_id;
      logic [15:0] byte_count;
      logic [7:0]  fmt_type;
      logic [23:0] length;
   } tlp_cpl_hdr_t;

   typedef union packed {
      tlp_req_hdr_t req;
      tlp_cpl_hdr_t cpl;
   } tlp_hdr01_u;

   function automatic logic [31:0] swap_dw(input logic [31:0] d);
      return {d[7:0], d[15:8], d[23:16], d[31:24]};
   endfunction

endpackage
